/* verilog.f */
rtl/ll_pkg.sv
rtl/ll_sync_if.sv
rtl/ll_auto_sync.sv
rtl/ll_receive.sv
rtl/st_slave_phy_unpack.sv
rtl/st_slave_user_if.sv
rtl/st_slave_top.sv
verification/st_slave_tb.sv

/* verification/st_slave_tb.sv */
//////////////////////////////////////////////////
// Testbench for the stream link slave. Models a
// credit based link master on the PHY lanes, checks
// the online sequencing, the user stream in both
// generation modes, back-pressure and overflow.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module st_slave_tb
  import ll_pkg::*;
();

  localparam int DELAY_X     = 20;
  localparam int DELAY_Y     = 10;
  localparam int EARLY_WORDS = 3;
  localparam int GEN2_WORDS  = 50;
  localparam int GEN1_WORDS  = 20;
  localparam int BP_WORDS    = 50;
  localparam int OVF_WORDS   = 12;
  localparam int ALL_WORDS   = 2 * EARLY_WORDS + GEN2_WORDS + GEN1_WORDS + BP_WORDS + OVF_WORDS;
  localparam int WATCHDOG    = ALL_WORDS * 40 + 2000;
  localparam int STARVE_MAX  = 64;

  logic                 clk;
  logic                 rst;
  logic                 tx_online;
  logic                 rx_online;
  logic [LANE_W-1:0]    rx_phy0;
  logic [LANE_W-1:0]    rx_phy1;
  logic [LANE_W-1:0]    tx_phy0;
  logic [LANE_W-1:0]    tx_phy1;
  logic [DATA_W-1:0]    user_tdata;
  logic                 user_tvalid;
  logic                 user_tready;
  logic [EN_W-1:0]      user_enable;
  dbg_t                 rx_st_debug_status;
  logic                 m_gen2_mode;
  logic [NUM_LANES-1:0] tx_mrk_userbit;
  logic [15:0]          delay_x_value;
  logic [15:0]          delay_y_value;

  int       seed       = 32'h5631;
  int       ready_seed = 32'h5631;
  int       errors     = 0;
  int       checks     = 0;
  int       credit     = FIFO_DEPTH;
  int       credit_seen;
  int       hs_count;
  bit       hs_prev;
  bit       rand_ready;
  ll_word_t exp_q [$];

  st_slave_top st_slave_top_inst (
    .clk_wr             (clk),
    .rst                (rst),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .user_tdata         (user_tdata),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .user_enable        (user_enable),
    .rx_st_debug_status (rx_st_debug_status),
    .m_gen2_mode        (m_gen2_mode),
    .tx_mrk_userbit     (tx_mrk_userbit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model and compare tasks

  // User view of a FIFO word in the given mode
  function automatic ll_word_t expected_word(input ll_word_t w, input logic gen2);
    ll_word_t r;
    r = w;
    if (!gen2) begin
      r.en   = 2'b01;
      r.data = {{(DATA_W - HALF_W){1'b0}}, w.data[HALF_W-1:0]};
    end
    return r;
  endfunction

  // Transmit lane with strobe, marker and credit and all other bits zero
  function automatic logic [LANE_W-1:0] expected_lane(input logic stb, input logic mrk,
                                                      input logic cred);
    logic [LANE_W-1:0] l;
    l             = '0;
    l[STB_BIT]    = stb;
    l[MRK_BIT]    = mrk;
    l[CREDIT_BIT] = cred;
    return l;
  endfunction

  // Word bits go to lane 0 bits 2..38, then lane 1 skipping the strobe bit
  function automatic logic [2*LANE_W-1:0] pack_lanes(input ll_word_t w);
    logic [LANE_W-1:0] l0;
    logic [LANE_W-1:0] l1;
    int                idx;
    l0  = '0;
    l1  = '0;
    idx = 0;
    for (int b = STB_BIT + 1; b < MRK_BIT; b++) begin
      l0[b] = w[idx];
      idx++;
    end
    for (int b = 0; b < MRK_BIT && idx < WORD_W; b++) begin
      if (b != STB_BIT) begin
        l1[b] = w[idx];
        idx++;
      end
    end
    l0[PUSH_BIT] = 1'b1;
    return {l1, l0};
  endfunction

  function automatic ll_word_t random_word();
    ll_word_t w;
    w.data = {$random(seed), $random(seed)};
    w.en   = $random(seed);
    return w;
  endfunction

  task automatic check_word(input ll_word_t got, input ll_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: user word en=%h data=%h, expected en=%h data=%h",
               $time, got.en, got.data, exp.en, exp.data);
    end
  endtask

  task automatic check_status(input dbg_t got, input dbg_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: debug status level=%0d ovf=%b, expected level=%0d ovf=%b",
               $time, got.level, got.overflow, exp.level, exp.overflow);
    end
  endtask

  task automatic check_lane(input string what, input logic [LANE_W-1:0] got,
                            input logic [LANE_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Link master and stream monitor

  // One word per falling edge and a wait for credit unless told otherwise
  task automatic push_word(input ll_word_t w, input bit use_credit, input bit expect_out);
    int waited;
    waited = 0;
    while (use_credit && credit <= 0) begin
      @(negedge clk);
      waited++;
      if (waited == STARVE_MAX) begin
        errors++;
        $display("Master starved: no credit returned for %0d cycles", STARVE_MAX);
      end
    end
    {rx_phy1, rx_phy0} = pack_lanes(w);
    if (use_credit) begin
      credit--;
    end
    if (expect_out) begin
      exp_q.push_back(w);
    end
    @(negedge clk);
    rx_phy0 = '0;
    rx_phy1 = '0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Stream stalled: %0d expected words never came out", exp_q.size());
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("Test %s: %s (%0d errors)", name,
             (errors == err_before) ? "ok" : "failed", errors - err_before);
  endtask

  // Handshakes and credits are sampled on the rising edge
  always @(posedge clk) begin
    ll_word_t w;
    ll_word_t got;
    if (!rst) begin
      // Credit bit follows a handshake by one cycle
      check_bit("credit bit", tx_phy0[CREDIT_BIT], hs_prev);
      if (tx_phy0[CREDIT_BIT]) begin
        credit++;
        credit_seen++;
      end
      if (user_tvalid && user_tready) begin
        hs_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected word on the user stream at %0t: data=%h", $time, user_tdata);
        end else begin
          w        = exp_q.pop_front();
          got.en   = user_enable;
          got.data = user_tdata;
          check_word(got, expected_word(w, m_gen2_mode));
        end
      end
      hs_prev = user_tvalid && user_tready;
    end
  end

  always @(negedge clk) begin
    int r;
    if (rand_ready) begin
      r           = $random(ready_seed);
      user_tready = r[0];
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  initial begin
    int err0;
    int hs0;
    int cr0;
    rst            = 1'b1;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    rx_phy0        = '0;
    rx_phy1        = '0;
    user_tready    = 1'b1;
    m_gen2_mode    = 1'b1;
    tx_mrk_userbit = 2'b10;
    delay_x_value  = 16'(DELAY_X);
    delay_y_value  = 16'(DELAY_Y);
    rand_ready     = 1'b0;
    credit_seen    = 0;
    hs_count       = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Online sequencing drops early words
    err0 = errors;
    check_bit("user_tvalid after reset", user_tvalid, 1'b0);
    check_lane("tx_phy0 after reset", tx_phy0, expected_lane(1'b0, tx_mrk_userbit[0], 1'b0));
    check_lane("tx_phy1 after reset", tx_phy1, expected_lane(1'b0, tx_mrk_userbit[1], 1'b0));
    tx_online = 1'b1;
    for (int n = 1; n <= DELAY_X + 1; n++) begin
      @(negedge clk);
      check_lane("tx_phy0", tx_phy0, expected_lane(n >= DELAY_X, tx_mrk_userbit[0], 1'b0));
      check_lane("tx_phy1", tx_phy1, expected_lane(n >= DELAY_X, tx_mrk_userbit[1], 1'b0));
    end
    // Marker bits follow the input lane by lane
    tx_mrk_userbit = 2'b01;
    @(negedge clk);
    check_lane("tx_phy0 marker", tx_phy0, expected_lane(1'b1, 1'b1, 1'b0));
    check_lane("tx_phy1 marker", tx_phy1, expected_lane(1'b1, 1'b0, 1'b0));
    for (int i = 0; i < EARLY_WORDS; i++) begin
      push_word(random_word(), 1'b0, 1'b0);
    end
    repeat (3) @(negedge clk);
    check_status(rx_st_debug_status, '{rsvd: '0, overflow: 1'b0, level: 4'd0});
    // Still dropped while the receive delay runs
    rx_online = 1'b1;
    for (int i = 0; i < EARLY_WORDS; i++) begin
      push_word(random_word(), 1'b0, 1'b0);
    end
    repeat (2) @(negedge clk);
    check_status(rx_st_debug_status, '{rsvd: '0, overflow: 1'b0, level: 4'd0});
    repeat (DELAY_Y) @(negedge clk);
    end_test("online", err0);

    // Gen2 stream without back-pressure
    err0 = errors;
    for (int i = 0; i < GEN2_WORDS; i++) begin
      push_word(random_word(), 1'b1, 1'b1);
    end
    wait_drain(500);
    end_test("gen2", err0);

    // Gen1 stream
    err0 = errors;
    m_gen2_mode = 1'b0;
    for (int i = 0; i < GEN1_WORDS; i++) begin
      push_word(random_word(), 1'b1, 1'b1);
    end
    wait_drain(500);
    m_gen2_mode = 1'b1;
    end_test("gen1", err0);

    // Random back-pressure
    err0 = errors;
    repeat (3) @(negedge clk);
    hs0        = hs_count;
    cr0        = credit_seen;
    rand_ready = 1'b1;
    for (int i = 0; i < BP_WORDS; i++) begin
      push_word(random_word(), 1'b1, 1'b1);
    end
    wait_drain(1000);
    rand_ready  = 1'b0;
    user_tready = 1'b1;
    repeat (3) @(negedge clk);
    check_count("credits returned", credit_seen - cr0, hs_count - hs0);
    check_count("master credit", credit, FIFO_DEPTH);
    end_test("backpressure", err0);

    // Overflow with credits ignored
    err0        = errors;
    user_tready = 1'b0;
    hs0         = hs_count;
    for (int i = 0; i < OVF_WORDS; i++) begin
      push_word(random_word(), 1'b0, i < FIFO_DEPTH);
    end
    repeat (4) @(negedge clk);
    check_status(rx_st_debug_status, '{rsvd: '0, overflow: 1'b1, level: 4'(FIFO_DEPTH)});
    user_tready = 1'b1;
    wait_drain(200);
    repeat (3) @(negedge clk);
    check_count("words after overflow", hs_count - hs0, FIFO_DEPTH);
    check_status(rx_st_debug_status, '{rsvd: '0, overflow: 1'b1, level: 4'd0});
    end_test("overflow", err0);

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* rtl/st_slave_top.sv */
//////////////////////////////////////////////////
// Receive side of the parallel die-to-die stream
// link. Takes words from two PHY lanes as a link
// slave and offers them on a user valid/ready
// stream, returning credits on the transmit lanes.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module st_slave_top
  import ll_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 rst,

  // Link control
  input  logic                 tx_online,
  input  logic                 rx_online,

  // PHY lanes
  input  logic [LANE_W-1:0]    rx_phy0,
  input  logic [LANE_W-1:0]    rx_phy1,
  output logic [LANE_W-1:0]    tx_phy0,
  output logic [LANE_W-1:0]    tx_phy1,

  // User stream
  output logic [DATA_W-1:0]    user_tdata,
  output logic                 user_tvalid,
  input  logic                 user_tready,
  output logic [EN_W-1:0]      user_enable,

  output dbg_t                 rx_st_debug_status,

  // Configuration
  input  logic                 m_gen2_mode,
  input  logic [NUM_LANES-1:0] tx_mrk_userbit,
  input  logic [15:0]          delay_x_value,
  input  logic [15:0]          delay_y_value
);

  ll_word_t rx_word;
  logic     rx_push;
  logic     tx_credit;
  ll_word_t fifo_word;
  logic     fifo_valid;
  logic     fifo_ready;

  ll_sync_if sync_if ();

  //////////////////////////////////////////////////
  // Online sequencing
  ll_auto_sync ll_auto_sync_inst (
    .clk_wr         (clk_wr),
    .rst            (rst),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .sync           (sync_if.sync_src)
  );

  //////////////////////////////////////////////////
  // PHY lanes
  st_slave_phy_unpack st_slave_phy_unpack_inst (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .rx_phy0   (rx_phy0),
    .rx_phy1   (rx_phy1),
    .tx_phy0   (tx_phy0),
    .tx_phy1   (tx_phy1),
    .rx_word   (rx_word),
    .rx_push   (rx_push),
    .tx_credit (tx_credit),
    .sync      (sync_if.sync_sink)
  );

  //////////////////////////////////////////////////
  // Receive FIFO
  ll_receive ll_receive_inst (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .rx_word      (rx_word),
    .rx_push      (rx_push),
    .fifo_word    (fifo_word),
    .fifo_valid   (fifo_valid),
    .fifo_ready   (fifo_ready),
    .tx_credit    (tx_credit),
    .debug_status (rx_st_debug_status),
    .sync         (sync_if.link_sink)
  );

  //////////////////////////////////////////////////
  // User stream
  st_slave_user_if st_slave_user_if_inst (
    .fifo_word   (fifo_word),
    .fifo_valid  (fifo_valid),
    .fifo_ready  (fifo_ready),
    .user_tdata  (user_tdata),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready),
    .user_enable (user_enable),
    .m_gen2_mode (m_gen2_mode)
  );

endmodule

/* rtl/st_slave_user_if.sv */
//////////////////////////////////////////////////
// User stream mapping. Presents the FIFO head as a
// valid/ready stream, full width in gen2 mode and
// low half only in gen1 mode.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module st_slave_user_if
  import ll_pkg::*;
(
  input  ll_word_t          fifo_word,
  input  logic              fifo_valid,
  output logic              fifo_ready,
  output logic [DATA_W-1:0] user_tdata,
  output logic              user_tvalid,
  input  logic              user_tready,
  output logic [EN_W-1:0]   user_enable,
  input  logic              m_gen2_mode
);

  // Handshake passes straight through to the FIFO head
  assign user_tvalid = fifo_valid;
  assign fifo_ready  = user_tready;

  always_comb begin
    if (m_gen2_mode) begin
      user_tdata  = fifo_word.data;
      user_enable = fifo_word.en;
    end else begin
      // Gen1 carries a half word, upper half reads zero
      user_tdata  = {{(DATA_W - HALF_W){1'b0}}, fifo_word.data[HALF_W-1:0]};
      user_enable = EN_W'(1);
    end
  end

endmodule

/* rtl/st_slave_phy_unpack.sv */
//////////////////////////////////////////////////
// PHY lane adapter for the stream slave. Gathers
// the FIFO word from the receive lanes and builds
// the transmit lanes from credit, strobe and
// marker bits.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module st_slave_phy_unpack
  import ll_pkg::*;
(
  input  logic              clk_wr,
  input  logic              rst,
  input  logic [LANE_W-1:0] rx_phy0,
  input  logic [LANE_W-1:0] rx_phy1,
  output logic [LANE_W-1:0] tx_phy0,
  output logic [LANE_W-1:0] tx_phy1,
  output ll_word_t          rx_word,
  output logic              rx_push,
  input  logic              tx_credit,
  ll_sync_if.sync_sink      sync
);

  logic [WORD_W-1:0] rx_bits;
  logic [LANE_W-1:0] tx_lane [NUM_LANES];
  logic              credit_q;

  // Lane 0 bits 2..38, then lane 1 bit 0 and bits 2 upward
  assign rx_bits[L0_BITS-1:0]        = rx_phy0[MRK_BIT-1:STB_BIT+1];
  assign rx_bits[L0_BITS]            = rx_phy1[0];
  assign rx_bits[WORD_W-1:L0_BITS+1] = rx_phy1[STB_BIT+L1_BITS-1:STB_BIT+1];

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      rx_push  <= 1'b0;
      credit_q <= 1'b0;
    end else begin
      rx_push  <= rx_phy0[PUSH_BIT];
      credit_q <= tx_credit && sync.tx_online_delay;
    end
  end

  // Word register loads only on a push
  always_ff @(posedge clk_wr) begin
    if (rx_phy0[PUSH_BIT]) begin
      rx_word <= ll_word_t'(rx_bits);
    end
  end

  //////////////////////////////////////////////////
  // Transmit lanes
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      tx_lane[i]          = '0;
      tx_lane[i][STB_BIT] = sync.stb_userbit;
      tx_lane[i][MRK_BIT] = sync.mrk_userbit[i];
    end
    // Credit rides on lane 0 only
    tx_lane[0][CREDIT_BIT] = credit_q;
  end

  assign tx_phy0 = tx_lane[0];
  assign tx_phy1 = tx_lane[1];

endmodule

/* rtl/ll_receive.sv */
//////////////////////////////////////////////////
// Credit managed receive FIFO. Stores pushed words
// while receive is online, returns one credit per
// pop and reports fill level and a sticky overflow
// flag on the debug status.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module ll_receive
  import ll_pkg::*;
(
  input  logic         clk_wr,
  input  logic         rst,
  input  ll_word_t     rx_word,
  input  logic         rx_push,
  output ll_word_t     fifo_word,
  output logic         fifo_valid,
  input  logic         fifo_ready,
  output logic         tx_credit,
  output dbg_t         debug_status,
  ll_sync_if.link_sink sync
);

  ll_word_t         mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             ovf_sticky;
  logic             full;
  logic             push_req;
  logic             push_ok;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign push_req = rx_push && sync.rx_online_delay;
  assign push_ok  = push_req && !full;

  // Head word only offered while credits can go back
  assign fifo_valid = (count != '0) && sync.tx_online_delay;
  assign pop        = fifo_valid && fifo_ready;
  assign tx_credit  = pop;
  assign fifo_word  = mem[rd_ptr];

  //////////////////////////////////////////////////
  // Storage
  always_ff @(posedge clk_wr) begin
    if (push_ok) begin
      mem[wr_ptr] <= rx_word;
    end
  end

  //////////////////////////////////////////////////
  // Pointers and fill level
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Push into a full FIFO is lost
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      ovf_sticky <= 1'b0;
    end else if (push_req && full) begin
      ovf_sticky <= 1'b1;
    end
  end

  assign debug_status = '{rsvd: '0, overflow: ovf_sticky, level: count};

endmodule

/* rtl/ll_auto_sync.sv */
//////////////////////////////////////////////////
// Online sequencing for the link slave. Delays the
// transmit and receive online levels by programmable
// cycle counts and drives the strobe and marker
// user bits that go out on the transmit lanes.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module ll_auto_sync
  import ll_pkg::*;
(
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic                 tx_online,
  input  logic                 rx_online,
  input  logic [15:0]          delay_x_value,
  input  logic [15:0]          delay_y_value,
  input  logic [NUM_LANES-1:0] tx_mrk_userbit,
  ll_sync_if.sync_src          sync
);

  logic [15:0] cnt_x;
  logic [15:0] cnt_y;
  logic        tx_delay_q;
  logic        rx_delay_q;
  logic        rx_arm;

  // True once the next count reaches the programmed delay
  function automatic logic delay_done(input logic [15:0] cnt, input logic [15:0] limit);
    logic [16:0] next_cnt;
    next_cnt = {1'b0, cnt} + 17'd1;
    return next_cnt >= {1'b0, limit};
  endfunction

  // Receive waits for both its own level and the delayed transmit level
  assign rx_arm = rx_online && tx_delay_q;

  //////////////////////////////////////////////////
  // Transmit online delay
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_online) begin
      cnt_x      <= '0;
      tx_delay_q <= 1'b0;
    end else if (!tx_delay_q) begin
      cnt_x      <= cnt_x + 16'd1;
      tx_delay_q <= delay_done(cnt_x, delay_x_value);
    end
  end

  //////////////////////////////////////////////////
  // Receive online delay
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_arm) begin
      cnt_y      <= '0;
      rx_delay_q <= 1'b0;
    end else if (!rx_delay_q) begin
      cnt_y      <= cnt_y + 16'd1;
      rx_delay_q <= delay_done(cnt_y, delay_y_value);
    end
  end

  assign sync.tx_online_delay = tx_delay_q;
  assign sync.rx_online_delay = rx_delay_q;

  // Persistent strobe while transmit is online
  assign sync.stb_userbit = tx_delay_q;

  // Persistent marker, one bit per lane
  assign sync.mrk_userbit = tx_mrk_userbit;

endmodule

/* rtl/ll_sync_if.sv */
//////////////////////////////////////////////////
// Delayed online levels and user bits produced by
// the sync block. The unpacker reads all of them,
// the receive FIFO reads only the online levels.
//////////////////////////////////////////////////

`timescale 1ns/100ps

interface ll_sync_if
  import ll_pkg::*;
();

  logic                 tx_online_delay;
  logic                 rx_online_delay;
  logic [NUM_LANES-1:0] mrk_userbit;
  logic                 stb_userbit;

  modport sync_src (
    output tx_online_delay,
    output rx_online_delay,
    output mrk_userbit,
    output stb_userbit
  );

  modport sync_sink (
    input tx_online_delay,
    input rx_online_delay,
    input mrk_userbit,
    input stb_userbit
  );

  modport link_sink (
    input tx_online_delay,
    input rx_online_delay
  );

endinterface

/* rtl/ll_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, lane bit positions and word types
// for the receive side of the die-to-die link.
// Every link module takes this by wildcard import.
//////////////////////////////////////////////////

package ll_pkg;

  // PHY lanes
  localparam int LANE_W     = 40;
  localparam int NUM_LANES  = 2;

  // User stream
  localparam int DATA_W     = 64;
  localparam int HALF_W     = DATA_W / 2;
  localparam int EN_W       = 2;
  localparam int WORD_W     = DATA_W + EN_W;

  // Receive FIFO, also the master's initial credit
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);

  // Lane bit positions
  localparam int PUSH_BIT   = 0;
  localparam int CREDIT_BIT = 0;
  localparam int STB_BIT    = 1;
  localparam int MRK_BIT    = 39;

  // Word bits carried by lane 0 and lane 1
  localparam int L0_BITS    = MRK_BIT - STB_BIT - 1;
  localparam int L1_BITS    = WORD_W - L0_BITS;

  typedef struct packed {
    logic [EN_W-1:0]   en;
    logic [DATA_W-1:0] data;
  } ll_word_t;

  typedef struct packed {
    logic [2:0] rsvd;
    logic       overflow;
    logic [3:0] level;
  } dbg_t;

endpackage
